// ==== ad7124_params.svh ====
`ifndef AD7124_PARAMS_SVH
`define AD7124_PARAMS_SVH

////////////////////////////////////////////////////////////
// spi timing
////////////////////////////////////////////////////////////

// system clocks per sclk half period
`define AD7124_CLK_DIV     8
// idle clocks from end of frame to next go
`define AD7124_GAP_CYCLES  800

////////////////////////////////////////////////////////////
// frame geometry
////////////////////////////////////////////////////////////

`define AD7124_LEN_W       6
`define AD7124_FRAME_W     32
`define AD7124_SAMPLE_W    24
// comms byte plus status byte
`define AD7124_POLL_LEN    16
// comms byte plus 24-bit result
`define AD7124_READ_LEN    32
// rdy flag in status byte, low when a result is waiting
`define AD7124_RDY_BIT     7

////////////////////////////////////////////////////////////
// configuration writes, comms byte then payload
////////////////////////////////////////////////////////////

`define AD7124_CFG_COUNT   5
`define AD7124_CFG0        24'h01_0080
`define AD7124_CFG0_LEN    24
`define AD7124_CFG1        32'h03_001860
`define AD7124_CFG1_LEN    32
`define AD7124_CFG2        24'h09_80E8
`define AD7124_CFG2_LEN    24
`define AD7124_CFG3        24'h19_09E1
`define AD7124_CFG3_LEN    24
`define AD7124_CFG4        32'h21_0603C0
`define AD7124_CFG4_LEN    32

`endif

// ==== ad7124_pkg.sv ====
`include "ad7124_params.svh"

package ad7124_pkg;

    ////////////////////////////////////////////////////////////
    // sequencer states
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        IDLE,
        CFG_SEND,
        CFG_GAP,
        POLL_SEND,
        POLL_GAP,
        READ_SEND,
        READ_GAP,
        DONE
    } seq_state_t;

    // comms register opcodes, bit 6 selects read
    typedef enum logic [7:0] {
        WRITE_REG   = 8'h00,
        READ_STATUS = 8'h40,
        READ_DATA   = 8'h42
    } ad7124_cmd_t;

    ////////////////////////////////////////////////////////////
    // sequencer <-> spi engine
    ////////////////////////////////////////////////////////////

    // outgoing frame, bits sent from data msb down
    typedef struct packed {
        logic [`AD7124_LEN_W-1:0]   len;
        logic [`AD7124_FRAME_W-1:0] data;
    } spi_frame_t;

    // engine status, rx right-aligned and valid with done
    typedef struct packed {
        logic                       busy;
        logic                       done;
        logic [`AD7124_FRAME_W-1:0] rx;
    } spi_result_t;

endpackage

// ==== ad7124_spi_engine.sv ====
`timescale 1ns/1ps
`include "ad7124_params.svh"

module ad7124_spi_engine
    import ad7124_pkg::*;
(
    input  logic        PL_clk,
    input  logic        rst,
    input  spi_frame_t  frame,
    input  logic        go,
    input  logic        miso,
    output spi_result_t result,
    output logic        sclk,
    output logic        cs_n,
    output logic        mosi
);

    localparam int DIV_W = $clog2(`AD7124_CLK_DIV);

    logic [DIV_W-1:0]           div_cnt;
    logic                       half_tick;
    logic                       busy;
    logic                       done_p;
    logic [`AD7124_LEN_W-1:0]   bits_left;
    logic [`AD7124_FRAME_W-1:0] tx_sr;
    logic [`AD7124_FRAME_W-1:0] rx_sr;

    ////////////////////////////////////////////////////////////
    // half period divider
    ////////////////////////////////////////////////////////////

    // one tick every CLK_DIV clocks while a frame runs
    assign half_tick = busy && (div_cnt == DIV_W'(`AD7124_CLK_DIV - 1));

    always_ff @(posedge PL_clk or negedge rst) begin
        if (!rst) begin
            div_cnt <= '0;
        end else if (!busy || half_tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // frame control, mode 3
    ////////////////////////////////////////////////////////////

    // cs_n low the cycle after go, first sclk fall one half period later
    // done lands one half period after the last rise:
    // go to done = 1 + CLK_DIV * (2 * len + 1) clocks
    always_ff @(posedge PL_clk or negedge rst) begin
        if (!rst) begin
            busy      <= 1'b0;
            done_p    <= 1'b0;
            cs_n      <= 1'b1;
            sclk      <= 1'b1;
            mosi      <= 1'b0;
            bits_left <= '0;
        end else begin
            done_p <= 1'b0;
            if (go) begin
                busy      <= 1'b1;
                cs_n      <= 1'b0;
                bits_left <= frame.len;
            end else if (half_tick) begin
                if (bits_left == '0) begin
                    // trailing half period done, release the device
                    cs_n   <= 1'b1;
                    busy   <= 1'b0;
                    done_p <= 1'b1;
                    mosi   <= 1'b0;
                end else if (sclk) begin
                    // falling edge, next bit out
                    sclk <= 1'b0;
                    mosi <= tx_sr[`AD7124_FRAME_W-1];
                end else begin
                    // rising edge, device samples mosi
                    sclk      <= 1'b1;
                    bits_left <= bits_left - 1'b1;
                end
            end
        end
    end

    // shift registers
    always_ff @(posedge PL_clk) begin
        if (go) begin
            tx_sr <= frame.data;
            rx_sr <= '0;
        end else if (half_tick && bits_left != '0) begin
            if (sclk) begin
                tx_sr <= {tx_sr[`AD7124_FRAME_W-2:0], 1'b0};
            end else begin
                rx_sr <= {rx_sr[`AD7124_FRAME_W-2:0], miso};
            end
        end
    end

    assign result = '{busy: busy, done: done_p, rx: rx_sr};

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // sclk parks high whenever the device is deselected
    a_sclk_idle: assert property (@(posedge PL_clk) disable iff (!rst) cs_n |-> sclk)
        else $error("sclk low while cs_n high");

    // sequencer must wait for the running frame
    a_go_idle: assert property (@(posedge PL_clk) disable iff (!rst) go |-> !busy)
        else $error("go while engine busy");

endmodule

// ==== ad7124_sequencer.sv ====
`timescale 1ns/1ps
`include "ad7124_params.svh"

module ad7124_sequencer
    import ad7124_pkg::*;
(
    input  logic                        PL_clk,
    input  logic                        rst,
    input  logic                        start,
    input  spi_result_t                 result,
    output spi_frame_t                  frame,
    output logic                        go,
    output logic [`AD7124_SAMPLE_W-1:0] sample,
    output logic                        sample_valid,
    output logic                        done
);

    localparam int GAP_W = $clog2(`AD7124_GAP_CYCLES);

    seq_state_t                 state;
    logic [2:0]                 cfg_idx;
    logic [GAP_W-1:0]           gap_cnt;
    logic                       gap_run;
    logic                       gap_end;
    logic                       armed;
    logic                       rdy_n;
    logic [`AD7124_FRAME_W-1:0] cfg_word;
    logic [`AD7124_LEN_W-1:0]   cfg_len;

    ////////////////////////////////////////////////////////////
    // gap timer, restarts on every frame end
    ////////////////////////////////////////////////////////////

    // last gap cycle, go registered here lands GAP clocks after done
    assign gap_end = gap_run && (gap_cnt == GAP_W'(`AD7124_GAP_CYCLES - 2));

    always_ff @(posedge PL_clk or negedge rst) begin
        if (!rst) begin
            gap_run <= 1'b0;
            gap_cnt <= '0;
        end else if (result.done) begin
            gap_run <= 1'b1;
            gap_cnt <= '0;
        end else if (gap_end) begin
            gap_run <= 1'b0;
        end else if (gap_run) begin
            gap_cnt <= gap_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // frame select
    ////////////////////////////////////////////////////////////

    always_comb begin
        cfg_word = '0;
        cfg_len  = '0;
        case (cfg_idx)
            3'd0: begin
                cfg_word = `AD7124_FRAME_W'(`AD7124_CFG0);
                cfg_len  = `AD7124_LEN_W'(`AD7124_CFG0_LEN);
            end
            3'd1: begin
                cfg_word = `AD7124_FRAME_W'(`AD7124_CFG1);
                cfg_len  = `AD7124_LEN_W'(`AD7124_CFG1_LEN);
            end
            3'd2: begin
                cfg_word = `AD7124_FRAME_W'(`AD7124_CFG2);
                cfg_len  = `AD7124_LEN_W'(`AD7124_CFG2_LEN);
            end
            3'd3: begin
                cfg_word = `AD7124_FRAME_W'(`AD7124_CFG3);
                cfg_len  = `AD7124_LEN_W'(`AD7124_CFG3_LEN);
            end
            3'd4: begin
                cfg_word = `AD7124_FRAME_W'(`AD7124_CFG4);
                cfg_len  = `AD7124_LEN_W'(`AD7124_CFG4_LEN);
            end
            default: ;
        endcase
        // stable through each SEND state, engine takes it on go
        if (cfg_idx < 3'(`AD7124_CFG_COUNT)) begin
            frame.len  = cfg_len;
            frame.data = cfg_word << (`AD7124_FRAME_W - cfg_len);
        end else if (rdy_n) begin
            frame.len  = `AD7124_LEN_W'(`AD7124_POLL_LEN);
            frame.data = {READ_STATUS, 24'h0};
        end else begin
            frame.len  = `AD7124_LEN_W'(`AD7124_READ_LEN);
            frame.data = {READ_DATA, 24'h0};
        end
    end

    ////////////////////////////////////////////////////////////
    // main fsm
    ////////////////////////////////////////////////////////////

    always_ff @(posedge PL_clk or negedge rst) begin
        if (!rst) begin
            state        <= IDLE;
            cfg_idx      <= '0;
            go           <= 1'b0;
            sample_valid <= 1'b0;
            done         <= 1'b0;
            armed        <= 1'b0;
            rdy_n        <= 1'b1;
        end else begin
            go           <= 1'b0;
            sample_valid <= 1'b0;
            // start low re-arms and drops done
            if (!start) begin
                done  <= 1'b0;
                armed <= 1'b1;
            end
            case (state)
                IDLE: begin
                    // wait out any gap left by an aborted run
                    if (start && armed && !gap_run) begin
                        go    <= 1'b1;
                        armed <= 1'b0;
                        rdy_n <= 1'b1;
                        state <= CFG_SEND;
                    end
                end
                CFG_SEND, POLL_SEND, READ_SEND: begin
                    if (result.done && !start) begin
                        state   <= IDLE;
                        cfg_idx <= '0;
                    end else if (result.done) begin
                        case (state)
                            CFG_SEND: begin
                                cfg_idx <= cfg_idx + 1'b1;
                                state   <= CFG_GAP;
                            end
                            POLL_SEND: begin
                                rdy_n <= result.rx[`AD7124_RDY_BIT];
                                state <= POLL_GAP;
                            end
                            default: begin
                                sample_valid <= 1'b1;
                                done         <= 1'b1;
                                state        <= READ_GAP;
                            end
                        endcase
                    end
                end
                CFG_GAP, POLL_GAP, READ_GAP: begin
                    if (!start) begin
                        state   <= IDLE;
                        cfg_idx <= '0;
                    end else if (gap_end) begin
                        // config done moves on to polling, rdy low moves on to read
                        if (state == READ_GAP) begin
                            state <= DONE;
                        end else if (cfg_idx < 3'(`AD7124_CFG_COUNT)) begin
                            go    <= 1'b1;
                            state <= CFG_SEND;
                        end else begin
                            go    <= 1'b1;
                            state <= rdy_n ? POLL_SEND : READ_SEND;
                        end
                    end
                end
                DONE: begin
                    // hold until start is released
                    if (!start) begin
                        state   <= IDLE;
                        cfg_idx <= '0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // sample latched from the data frame
    always_ff @(posedge PL_clk) begin
        if (result.done && state == READ_SEND) begin
            sample <= result.rx[`AD7124_SAMPLE_W-1:0];
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    a_valid_pulse: assert property (
        @(posedge PL_clk) disable iff (!rst) sample_valid |=> !sample_valid)
        else $error("sample_valid longer than one cycle");

    a_done_rise: assert property (
        @(posedge PL_clk) disable iff (!rst) $rose(done) |-> sample_valid)
        else $error("done rose without sample_valid");

endmodule

// ==== ad7124_ctrl.sv ====
`timescale 1ns/1ps
`include "ad7124_params.svh"

module ad7124_ctrl
    import ad7124_pkg::*;
(
    input  logic                        PL_clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic                        miso,
    output logic                        sclk,
    output logic                        cs_n,
    output logic                        mosi,
    output logic [`AD7124_SAMPLE_W-1:0] sample,
    output logic                        sample_valid,
    output logic                        done
);

    ////////////////////////////////////////////////////////////
    // sequencer to engine link
    ////////////////////////////////////////////////////////////

    spi_frame_t  frame;
    spi_result_t result;
    logic        go;

    // register writes, status polls, data read
    ad7124_sequencer u_sequencer (
        .PL_clk       (PL_clk),
        .rst          (rst),
        .start        (start),
        .result       (result),
        .frame        (frame),
        .go           (go),
        .sample       (sample),
        .sample_valid (sample_valid),
        .done         (done)
    );

    // single mode 3 bus to the adc
    ad7124_spi_engine u_spi_engine (
        .PL_clk (PL_clk),
        .rst    (rst),
        .frame  (frame),
        .go     (go),
        .miso   (miso),
        .result (result),
        .sclk   (sclk),
        .cs_n   (cs_n),
        .mosi   (mosi)
    );

endmodule

// ==== ad7124_adc_model.sv ====
`timescale 1ns/1ps
`include "ad7124_params.svh"

module ad7124_adc_model
    import ad7124_pkg::*;
(
    input  logic                        sclk,
    input  logic                        cs_n,
    input  logic                        mosi,
    input  logic [1:0]                  busy_polls,
    input  logic [`AD7124_SAMPLE_W-1:0] sample_value,
    output logic                        miso
);

    // one entry per frame, data right-aligned as received
    spi_frame_t frame_log [$];

    spi_frame_t                 entry;
    logic [`AD7124_FRAME_W-1:0] rx_bits;
    logic [`AD7124_FRAME_W-1:0] resp;
    logic [7:0]                 status;
    logic                       cs_q;
    logic                       sclk_q;
    int                         bit_cnt;
    int                         polls_seen;

    initial begin
        miso       = 1'b0;
        rx_bits    = '0;
        resp       = '0;
        status     = '0;
        cs_q       = 1'b1;
        sclk_q     = 1'b1;
        bit_cnt    = 0;
        polls_seen = 0;
    end

    ////////////////////////////////////////////////////////////
    // bus edges, decoded from the previous levels
    ////////////////////////////////////////////////////////////

    always @(sclk or cs_n) begin
        if (cs_n !== cs_q) begin
            if (cs_n === 1'b0) begin
                // new frame
                bit_cnt = 0;
                rx_bits = '0;
                resp    = '0;
            end else if (bit_cnt > 0) begin
                // frame end, log what came in on mosi
                entry.len  = `AD7124_LEN_W'(bit_cnt);
                entry.data = rx_bits;
                frame_log.push_back(entry);
                miso = 1'b0;
            end
        end else if (cs_n === 1'b0 && sclk === 1'b1 && sclk_q === 1'b0) begin
            // rising sclk, device samples mosi
            rx_bits = {rx_bits[`AD7124_FRAME_W-2:0], mosi};
            bit_cnt = bit_cnt + 1;
            // comms byte complete, pick the answer
            if (bit_cnt == 8) begin
                if (rx_bits[7:0] == READ_STATUS) begin
                    status = '0;
                    status[`AD7124_RDY_BIT] = (polls_seen < busy_polls);
                    resp = {status, 24'h0};
                    polls_seen = polls_seen + 1;
                end else if (rx_bits[7:0] == READ_DATA) begin
                    resp = {sample_value, 8'h00};
                    // next conversion polls from zero again
                    polls_seen = 0;
                end
            end
        end else if (cs_n === 1'b0 && sclk === 1'b0 && sclk_q === 1'b1) begin
            // falling sclk, next answer bit out
            if (bit_cnt >= 8) begin
                miso = resp[`AD7124_FRAME_W-1];
                resp = {resp[`AD7124_FRAME_W-2:0], 1'b0};
            end else begin
                miso = 1'b0;
            end
        end
        cs_q   = cs_n;
        sclk_q = sclk;
    end

endmodule

// ==== tb_ad7124_ctrl.sv ====
`timescale 1ns/1ps
`include "ad7124_params.svh"

module tb_ad7124_ctrl
    import ad7124_pkg::*;
();

    localparam int WAIT_LIMIT  = 20000;
    localparam int HOLD_CYCLES = 2000;

    logic                        PL_clk;
    logic                        rst;
    logic                        start;
    logic                        miso;
    logic                        sclk;
    logic                        cs_n;
    logic                        mosi;
    logic [`AD7124_SAMPLE_W-1:0] sample;
    logic                        sample_valid;
    logic                        done;
    logic [1:0]                  busy_polls;
    logic [`AD7124_SAMPLE_W-1:0] sample_value;

    // fsm state by name in the waves
    seq_state_t seq_state;

    spi_frame_t got_frame;
    spi_frame_t exp_frame;
    int         errors;
    int         err_mark;
    int         tests_passed;
    int         tests_failed;
    int         run_base;
    int         checked;
    int         cur_k;

    ad7124_ctrl ad7124_ctrl_inst (
        .PL_clk       (PL_clk),
        .rst          (rst),
        .start        (start),
        .miso         (miso),
        .sclk         (sclk),
        .cs_n         (cs_n),
        .mosi         (mosi),
        .sample       (sample),
        .sample_valid (sample_valid),
        .done         (done)
    );

    ad7124_adc_model adc_model_inst (
        .sclk         (sclk),
        .cs_n         (cs_n),
        .mosi         (mosi),
        .busy_polls   (busy_polls),
        .sample_value (sample_value),
        .miso         (miso)
    );

    assign seq_state = ad7124_ctrl_inst.u_sequencer.state;

    initial begin
        PL_clk = 1'b0;
        forever #50 PL_clk = ~PL_clk;
    end

    ////////////////////////////////////////////////////////////
    // expected mosi frames of one conversion
    ////////////////////////////////////////////////////////////

    // five writes, k+1 status polls, one data read
    // len 0 means no frame expected at idx
    function automatic spi_frame_t expected_frame(input int idx, input int k);
        spi_frame_t f;
        f.len  = '0;
        f.data = '0;
        case (idx)
            0: f = '{len: `AD7124_LEN_W'(24), data: `AD7124_FRAME_W'(`AD7124_CFG0)};
            1: f = '{len: `AD7124_LEN_W'(32), data: `AD7124_FRAME_W'(`AD7124_CFG1)};
            2: f = '{len: `AD7124_LEN_W'(24), data: `AD7124_FRAME_W'(`AD7124_CFG2)};
            3: f = '{len: `AD7124_LEN_W'(24), data: `AD7124_FRAME_W'(`AD7124_CFG3)};
            4: f = '{len: `AD7124_LEN_W'(32), data: `AD7124_FRAME_W'(`AD7124_CFG4)};
            default: begin
                if (idx < 6 + k) begin
                    f.len  = `AD7124_LEN_W'(16);
                    f.data = {16'h0, 8'h40, 8'h00};
                end else if (idx == 6 + k) begin
                    f.len  = `AD7124_LEN_W'(32);
                    f.data = {8'h42, 24'h0};
                end
            end
        endcase
        return f;
    endfunction

    ////////////////////////////////////////////////////////////
    // monitors
    ////////////////////////////////////////////////////////////

    // each logged frame against the reference, in order
    always @(negedge PL_clk) begin
        if (adc_model_inst.frame_log.size() > checked) begin
            got_frame = adc_model_inst.frame_log[checked];
            exp_frame = expected_frame(checked - run_base, cur_k);
            assert (got_frame == exp_frame) else begin
                $display("ERR %0t: frame %0d got len %0d data %h, expected len %0d data %h",
                         $time, checked - run_base, got_frame.len, got_frame.data,
                         exp_frame.len, exp_frame.data);
                errors++;
            end
            checked++;
        end
    end

    // sclk parked high while deselected
    always @(negedge PL_clk) begin
        if (rst) begin
            assert (sclk || !cs_n) else begin
                $display("ERR %0t: sclk low while cs_n high", $time);
                errors++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // test steps
    ////////////////////////////////////////////////////////////

    task automatic close_test(input string name);
        if (errors == err_mark) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_mark);
        end
    endtask

    task automatic run_conversion(input int n);
        int cycles;
        err_mark = errors;
        run_base = checked;
        @(posedge PL_clk);
        #5;
        cur_k        = $urandom % 4;
        busy_polls   = 2'(cur_k);
        sample_value = `AD7124_SAMPLE_W'($urandom);
        start        = 1'b1;
        cycles = 0;
        @(negedge PL_clk);
        while (!sample_valid && cycles < WAIT_LIMIT) begin
            @(negedge PL_clk);
            cycles++;
        end
        if (!sample_valid) begin
            $display("timeout: sample_valid never pulsed in conversion %0d", n);
            $display("TEST FAILED");
            $finish;
        end
        assert (sample == sample_value) else begin
            $display("ERR %0t: sample %h, expected %h", $time, sample, sample_value);
            errors++;
        end
        assert (done) else begin
            $display("ERR %0t: done low with sample_valid", $time);
            errors++;
        end
        @(negedge PL_clk);
        assert (!sample_valid) else begin
            $display("ERR %0t: sample_valid longer than one cycle", $time);
            errors++;
        end
        assert (adc_model_inst.frame_log.size() - run_base == 7 + cur_k) else begin
            $display("ERR %0t: %0d frames, expected %0d", $time,
                     adc_model_inst.frame_log.size() - run_base, 7 + cur_k);
            errors++;
        end
        close_test($sformatf("conversion %0d with %0d busy polls", n, cur_k));
    endtask

    task automatic hold_and_release(input int n);
        int frames_held;
        err_mark    = errors;
        frames_held = adc_model_inst.frame_log.size();
        // done level and a quiet bus while start stays high
        repeat (HOLD_CYCLES) begin
            @(negedge PL_clk);
            assert (done) else begin
                $display("ERR %0t: done low while start held", $time);
                errors++;
            end
        end
        assert (adc_model_inst.frame_log.size() == frames_held) else begin
            $display("ERR %0t: frame sent while start held", $time);
            errors++;
        end
        @(posedge PL_clk);
        #5;
        start = 1'b0;
        @(negedge PL_clk);
        assert (done) else begin
            $display("ERR %0t: done fell before the clock edge", $time);
            errors++;
        end
        @(negedge PL_clk);
        assert (!done) else begin
            $display("ERR %0t: done high one cycle after start release", $time);
            errors++;
        end
        repeat (10) @(posedge PL_clk);
        close_test($sformatf("hold and release %0d", n));
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst          = 1'b0;
        start        = 1'b0;
        busy_polls   = '0;
        sample_value = '0;
        errors       = 0;
        err_mark     = 0;
        tests_passed = 0;
        tests_failed = 0;
        run_base     = 0;
        checked      = 0;
        cur_k        = 0;
        void'($urandom(32'hddde_da88));
        repeat (4) @(posedge PL_clk);
        #5;
        rst = 1'b1;

        // idle levels out of reset
        @(negedge PL_clk);
        assert (cs_n && sclk && !mosi && !sample_valid && !done) else begin
            $display("ERR %0t: outputs not idle after reset", $time);
            errors++;
        end
        close_test("reset state");

        run_conversion(1);
        hold_and_release(1);
        run_conversion(2);
        hold_and_release(2);

        $display("passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== ad7124_ctrl.f ====
+incdir+.
ad7124_pkg.sv
ad7124_spi_engine.sv
ad7124_sequencer.sv
ad7124_ctrl.sv
ad7124_adc_model.sv
tb_ad7124_ctrl.sv

// ==== Bender.yml ====
package:
  name: ad7124_ctrl

sources:
  - include_dirs:
      - .
    files:
      - ad7124_pkg.sv
      - ad7124_spi_engine.sv
      - ad7124_sequencer.sv
      - ad7124_ctrl.sv
  - target: test
    include_dirs:
      - .
    files:
      - ad7124_adc_model.sv
      - tb_ad7124_ctrl.sv
